// File: rtl/ray_pkg.sv
`default_nettype none

package ray_pkg;

	// Coordinate fields limit the image to 1024 by 1024 pixels.
	localparam int COORD_W = 10;

	localparam int PIX_ID_W = 20;

	// Vector components are signed integers, so every result is exact.
	localparam int VEC_W = 24;

	typedef struct packed {
		logic signed [VEC_W-1:0] x;
		logic signed [VEC_W-1:0] y;
		logic signed [VEC_W-1:0] z;
	} vec_t;

	// Eye position and the three basis vectors of the view.
	typedef struct packed {
		vec_t e;
		vec_t u;
		vec_t v;
		vec_t w;
	} camera_t;

	typedef struct packed {
		logic [PIX_ID_W-1:0] pixel_id;
		logic [COORD_W-1:0]  x;
		logic [COORD_W-1:0]  y;
	} pixel_t;

	// One primary ray as handed to the shader.
	typedef struct packed {
		logic [PIX_ID_W-1:0] pixel_id;
		vec_t                origin;
		vec_t                dir;
	} ray_t;

	typedef enum logic {
		IDLE   = 1'b0,
		ACTIVE = 1'b1
	} scan_state_e;

endpackage : ray_pkg

`default_nettype wire

// File: rtl/pixel_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_scanner #(
	parameter int COLS = 8,
	parameter int ROWS = 6
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  ray_pkg::camera_t cam,
	input  logic             issue_ok,
	output logic             pix_valid,
	output ray_pkg::pixel_t  pix,
	output ray_pkg::camera_t frame_cam,
	output logic             busy
);
	import ray_pkg::*;

	localparam int NUM_PIX = COLS * ROWS;

	scan_state_e         state;
	camera_t             cam_q;
	logic [COORD_W-1:0]  x;
	logic [COORD_W-1:0]  y;
	logic [PIX_ID_W-1:0] pix_id;
	logic                issue;
	logic                x_last;
	logic                pix_last;

	// A pixel goes out whenever the frame is running and the pipeline has credit.
	assign issue    = (state == ACTIVE) && issue_ok;
	assign x_last   = (x == COORD_W'(COLS - 1));
	assign pix_last = (pix_id == PIX_ID_W'(NUM_PIX - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						state <= ACTIVE;
					end
				end
				ACTIVE: begin
					if (issue && pix_last) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// The counters return to zero after the last pixel, ready for the next frame.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			x      <= '0;
			y      <= '0;
			pix_id <= '0;
		end else if (issue) begin
			if (pix_last) begin
				x      <= '0;
				y      <= '0;
				pix_id <= '0;
			end else begin
				pix_id <= pix_id + 1'b1;
				if (x_last) begin
					x <= '0;
					y <= y + 1'b1;
				end else begin
					x <= x + 1'b1;
				end
			end
		end
	end

	// The camera is sampled once per frame and held until the next start.
	always_ff @(posedge clk) begin
		if ((state == IDLE) && start) begin
			cam_q <= cam;
		end
	end

	assign pix_valid    = issue;
	assign pix.pixel_id = pix_id;
	assign pix.x        = x;
	assign pix.y        = y;
	assign frame_cam    = cam_q;
	assign busy         = (state == ACTIVE);

endmodule : pixel_scanner

`default_nettype wire

// File: rtl/ray_dir_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module ray_dir_pipe #(
	parameter int COLS       = 8,
	parameter int ROWS       = 6,
	parameter int FIFO_DEPTH = 8
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        pix_valid,
	input  ray_pkg::pixel_t             pix,
	input  ray_pkg::camera_t            frame_cam,
	input  logic [$clog2(FIFO_DEPTH):0] free_count,
	output logic                        issue_ok,
	output logic                        out_valid,
	output ray_pkg::ray_t               out_ray
);
	import ray_pkg::*;

	localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;
	localparam int OFF_W = COORD_W + 1;

	logic                    s1_valid;
	logic [PIX_ID_W-1:0]     s1_id;
	logic signed [OFF_W-1:0] s1_dx;
	logic signed [OFF_W-1:0] s1_dy;
	camera_t                 s1_cam;

	logic                    s2_valid;
	logic [PIX_ID_W-1:0]     s2_id;
	vec_t                    s2_du;
	vec_t                    s2_dv;
	vec_t                    s2_w;
	vec_t                    s2_e;

	logic [1:0]              in_flight;

	// Scales every component of a vector by a signed pixel offset.
	function automatic vec_t vec_scale(input logic signed [OFF_W-1:0] k, input vec_t a);
		vec_t r;
		r.x = k * a.x;
		r.y = k * a.y;
		r.z = k * a.z;
		return r;
	endfunction

	function automatic vec_t vec_add3(input vec_t a, input vec_t b, input vec_t c);
		vec_t r;
		r.x = a.x + b.x + c.x;
		r.y = a.y + b.y + c.y;
		r.z = a.z + b.z + c.z;
		return r;
	endfunction

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s1_valid  <= pix_valid;
			s2_valid  <= s1_valid;
			out_valid <= s2_valid;
		end
	end

	// The camera travels with each pixel, so rays still in flight keep
	// the view they were issued under even if a new frame latches another.
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			s1_id  <= pix.pixel_id;
			s1_dx  <= $signed({1'b0, pix.x}) - OFF_W'(COLS / 2);
			s1_dy  <= OFF_W'(ROWS / 2 - 1) - $signed({1'b0, pix.y});
			s1_cam <= frame_cam;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			s2_id <= s1_id;
			s2_du <= vec_scale(s1_dx, s1_cam.u);
			s2_dv <= vec_scale(s1_dy, s1_cam.v);
			s2_w  <= s1_cam.w;
			s2_e  <= s1_cam.e;
		end
	end

	always_ff @(posedge clk) begin
		if (s2_valid) begin
			out_ray.pixel_id <= s2_id;
			out_ray.origin   <= s2_e;
			out_ray.dir      <= vec_add3(s2_w, s2_du, s2_dv);
		end
	end

	// Counts rays in the three stages, including the one being written now.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			in_flight <= '0;
		end else if (pix_valid && !out_valid) begin
			in_flight <= in_flight + 2'd1;
		end else if (!pix_valid && out_valid) begin
			in_flight <= in_flight - 2'd1;
		end
	end

	assign issue_ok = (free_count > CNT_W'(in_flight));

endmodule : ray_dir_pipe

`default_nettype wire

// File: rtl/ray_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ray_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        wr,
	input  ray_pkg::ray_t               wr_ray,
	input  logic                        ray_stall,
	output logic                        ray_valid,
	output ray_pkg::ray_t               ray,
	output logic [$clog2(FIFO_DEPTH):0] free_count
);
	import ray_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	ray_t             mem [FIFO_DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// Pointer step that also works for depths that are not a power of two.
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		logic [PTR_W-1:0] n;
		if (p == PTR_W'(FIFO_DEPTH - 1)) begin
			n = '0;
		end else begin
			n = p + 1'b1;
		end
		return n;
	endfunction

	assign push = wr && (count != CNT_W'(FIFO_DEPTH));
	assign pop  = ray_valid && !ray_stall;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= wr_ray;
		end
	end

	// The head entry is shown ahead and stays put while the shader stalls.
	assign ray        = mem[rd_ptr];
	assign ray_valid  = (count != '0);
	assign free_count = CNT_W'(FIFO_DEPTH) - count;

endmodule : ray_fifo

`default_nettype wire

// File: rtl/ray_gen_top.sv
`timescale 1ns/1ps
`default_nettype none

module ray_gen_top #(
	parameter int COLS       = 8,
	parameter int ROWS       = 6,
	parameter int FIFO_DEPTH = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  ray_pkg::camera_t cam,
	input  logic             ray_stall,
	output logic             ray_valid,
	output ray_pkg::ray_t    ray,
	output logic             busy
);
	import ray_pkg::*;

	logic                        pix_valid;
	pixel_t                      pix;
	camera_t                     frame_cam;
	logic                        issue_ok;
	logic                        out_valid;
	ray_t                        out_ray;
	logic [$clog2(FIFO_DEPTH):0] free_count;

	pixel_scanner #(
		.COLS(COLS),
		.ROWS(ROWS)
	) u_scanner (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.cam       (cam),
		.issue_ok  (issue_ok),
		.pix_valid (pix_valid),
		.pix       (pix),
		.frame_cam (frame_cam),
		.busy      (busy)
	);

	ray_dir_pipe #(
		.COLS      (COLS),
		.ROWS      (ROWS),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_pipe (
		.clk        (clk),
		.rst        (rst),
		.pix_valid  (pix_valid),
		.pix        (pix),
		.frame_cam  (frame_cam),
		.free_count (free_count),
		.issue_ok   (issue_ok),
		.out_valid  (out_valid),
		.out_ray    (out_ray)
	);

	ray_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk        (clk),
		.rst        (rst),
		.wr         (out_valid),
		.wr_ray     (out_ray),
		.ray_stall  (ray_stall),
		.ray_valid  (ray_valid),
		.ray        (ray),
		.free_count (free_count)
	);

endmodule : ray_gen_top

`default_nettype wire

// File: tests/ray_gen_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ray_gen_checker (
	input  logic          clk,
	input  logic          rst,
	input  logic          start,
	input  logic          ray_stall,
	input  logic          ray_valid,
	input  ray_pkg::ray_t ray,
	input  logic          busy
);

	// Nothing may leave the FIFO while reset is held.
	a_no_valid_in_reset: assert property (@(posedge clk) rst |-> !ray_valid)
		else $error("ray_valid high while reset is asserted");

	// A stalled head stays on the port until the shader takes it.
	a_stall_holds_head: assert property (@(posedge clk) disable iff (rst)
		(ray_valid && ray_stall) |=> (ray_valid && $stable(ray)))
		else $error("head ray changed or vanished while the shader stalled");

	// A frame begins only after a start pulse.
	a_busy_needs_start: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> $past(start))
		else $error("busy rose without a start pulse");

endmodule : ray_gen_checker

bind ray_gen_top ray_gen_checker u_checker (
	.clk       (clk),
	.rst       (rst),
	.start     (start),
	.ray_stall (ray_stall),
	.ray_valid (ray_valid),
	.ray       (ray),
	.busy      (busy)
);

`default_nettype wire

// File: tests/ray_gen_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ray_gen_tb;
	import ray_pkg::*;

	localparam int COLS       = 8;
	localparam int ROWS       = 6;
	localparam int FIFO_DEPTH = 8;
	localparam int NUM_PIX    = COLS * ROWS;

	// The limit covers four frames at up to four cycles per ray, doubled for stalls.
	localparam int TOTAL_RAYS     = 4 * NUM_PIX;
	localparam int STALL_FACTOR   = 2;
	localparam int MARGIN         = 500;
	localparam int TIMEOUT_CYCLES = 4 * TOTAL_RAYS * STALL_FACTOR + MARGIN;

	logic    clk;
	logic    rst;
	logic    start;
	camera_t cam;
	logic    ray_stall;
	logic    ray_valid;
	ray_t    ray;
	logic    busy;

	int      seed = 32'h07e98716;
	int      stall_rnd;
	logic    stall_en;
	camera_t exp_cam;
	vec_t    exp_dir;
	int      rx_count;
	int      errors;
	int      tests_run;
	int      tests_failed;
	int      cycles;
	string   test_name;
	camera_t cam_a;
	camera_t cam_b;

	ray_gen_top #(
		.COLS      (COLS),
		.ROWS      (ROWS),
		.FIFO_DEPTH(FIFO_DEPTH)
	) DUT (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.cam       (cam),
		.ray_stall (ray_stall),
		.ray_valid (ray_valid),
		.ray       (ray),
		.busy      (busy)
	);

	always #20 clk = ~clk;

	// The primary ray through a pixel points along W + dx*U + dy*V.
	function automatic vec_t ref_dir(input camera_t c, input int id);
		int   px;
		int   py;
		int   dx;
		int   dy;
		vec_t d;
		px  = id % COLS;
		py  = id / COLS;
		dx  = px - COLS / 2;
		dy  = ROWS / 2 - 1 - py;
		d.x = VEC_W'(c.w.x + dx * c.u.x + dy * c.v.x);
		d.y = VEC_W'(c.w.y + dx * c.u.y + dy * c.v.y);
		d.z = VEC_W'(c.w.z + dx * c.u.z + dy * c.v.z);
		return d;
	endfunction

	function automatic vec_t random_vec();
		vec_t v;
		v.x = VEC_W'($random(seed) % 5000);
		v.y = VEC_W'($random(seed) % 5000);
		v.z = VEC_W'($random(seed) % 5000);
		return v;
	endfunction

	function automatic camera_t random_camera();
		camera_t c;
		c.e = random_vec();
		c.u = random_vec();
		c.v = random_vec();
		c.w = random_vec();
		return c;
	endfunction

	// The shader stalls on about half the cycles while back-pressure is enabled.
	always @(posedge clk) begin
		if (stall_en) begin
			stall_rnd = $random(seed);
			ray_stall <= stall_rnd[0];
		end else begin
			ray_stall <= 1'b0;
		end
	end

	// Every ray the shader accepts is checked in order against the reference.
	always @(posedge clk) begin
		if (!rst && ray_valid && !ray_stall) begin
			assert (rx_count < NUM_PIX) else begin
				$display("Test %s: unexpected ray with pixel_id %0d after the frame ended",
					test_name, ray.pixel_id);
				errors++;
			end
			if (rx_count < NUM_PIX) begin
				exp_dir = ref_dir(exp_cam, rx_count);
				assert (ray.pixel_id == PIX_ID_W'(rx_count)) else begin
					$display("Mismatch %s pixel_id expected %0d actual %0d",
						test_name, rx_count, ray.pixel_id);
					errors++;
				end
				assert (ray.origin == exp_cam.e) else begin
					$display("Mismatch %s origin expected %h actual %h",
						test_name, exp_cam.e, ray.origin);
					errors++;
				end
				assert (ray.dir == exp_dir) else begin
					$display("Mismatch %s dir expected %h actual %h",
						test_name, exp_dir, ray.dir);
					errors++;
				end
			end
			rx_count <= rx_count + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles in test %s, the frame did not complete",
				cycles, test_name);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic report(input string name, input int err0);
		tests_run++;
		if (errors > err0) begin
			tests_failed++;
		end
		$display("Test %s finished: %0d rays, %0d errors", name, rx_count, errors - err0);
	endtask

	task automatic check_idle(input string name, input int n);
		int err0;
		err0      = errors;
		test_name = name;
		repeat (n) begin
			@(posedge clk);
			assert (!ray_valid && !busy) else begin
				$display("Test %s: ray_valid or busy went high with no start", name);
				errors++;
			end
		end
		report(name, err0);
	endtask

	task automatic run_frame(input string name, input bit stalls, input bit restart,
		input bit swap_cam, input camera_t c);
		int err0;
		err0      = errors;
		test_name = name;
		rx_count <= 0;
		stall_en <= stalls;
		cam      <= c;
		exp_cam  <= c;
		start    <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (!busy) begin
			@(posedge clk);
		end
		// The frame was latched at start, so this must not show in the rays.
		if (swap_cam) begin
			cam <= random_camera();
		end
		if (restart) begin
			repeat (3) @(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		while (rx_count < NUM_PIX) begin
			@(posedge clk);
		end
		stall_en <= 1'b0;
		assert (!busy) else begin
			$display("Test %s: busy still high after the last ray", name);
			errors++;
		end
		repeat (20) @(posedge clk);
		assert (!busy && !ray_valid) else begin
			$display("Test %s: generator did not return to idle after the frame", name);
			errors++;
		end
		report(name, err0);
	endtask

	initial begin
		clk          = 1'b0;
		rst          = 1'b1;
		start        = 1'b0;
		cam          = '0;
		ray_stall    = 1'b0;
		stall_en     = 1'b0;
		exp_cam      = '0;
		rx_count     = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		cycles       = 0;
		test_name    = "reset";
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		check_idle("reset", 20);
		cam_a = random_camera();
		run_frame("full_frame", 1'b0, 1'b0, 1'b0, cam_a);
		run_frame("back_pressure", 1'b1, 1'b0, 1'b0, cam_a);
		run_frame("start_while_busy", 1'b0, 1'b1, 1'b1, cam_a);
		cam_b = random_camera();
		run_frame("second_frame", 1'b0, 1'b0, 1'b1, cam_b);

		$display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule : ray_gen_tb

`default_nettype wire

// File: list.f
rtl/ray_pkg.sv
rtl/pixel_scanner.sv
rtl/ray_dir_pipe.sv
rtl/ray_fifo.sv
rtl/ray_gen_top.sv
tests/ray_gen_checker.sv
tests/ray_gen_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the ray generator testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module ray_gen_tb \
	-f list.f -o ray_gen_sim > build.log 2>&1 \
	&& ./obj_dir/ray_gen_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2> /dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log

grep -q -F ">>> FAIL" sim.log \
	&& { echo "Simulation reported failure"; exit 1; } \
	|| { echo "Simulation finished without failure"; exit 0; }
